//--- video_macros.svh
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// Tile layer count
// The design supports 1 to 4 layers
`define NUM_LAYERS 2

// Width of a layer index
// Wide enough for the largest layer count
`define LAYER_BITS 2

// Horizontal geometry in pixels
// 6 MHz pixel clock, 384 pixels per line
`define H_TOTAL  384
`define H_ACTIVE 256
// Horizontal sync window, start inclusive and end exclusive
`define HS_START 288
`define HS_END   320

// Vertical geometry in lines
// 264 lines per frame, 224 of them visible
`define V_TOTAL  264
`define V_ACTIVE 224
// Vertical sync window, start inclusive and end exclusive
`define VS_START 232
`define VS_END   240

`endif

//--- video_pkg.sv
`include "video_macros.svh"

package video_pkg;

    // Raster position plus the blanking and sync flags
    // All fields are registered together in the timer
    typedef struct packed {
        logic [8:0] h;
        logic [8:0] v;
        // High while h is inside the visible line
        logic       lhbl;
        // High while v is inside the visible frame
        logic       lvbl;
        logic       hs;
        logic       vs;
    } timing_t;

    // Scroll offsets of one layer
    // hscroll wraps at 512, vscroll at 256
    typedef struct packed {
        logic [8:0] hscroll;
        logic [7:0] vscroll;
    } scroll_t;

    // Register select opcode of a CPU write
    typedef enum logic [1:0] {
        REG_HSCROLL_LO = 2'd0,
        REG_HSCROLL_HI = 2'd1,
        REG_VSCROLL    = 2'd2
    } reg_sel_e;

    // One CPU write, valid while wr is high
    typedef struct packed {
        logic                   wr;
        logic [`LAYER_BITS-1:0] layer;
        reg_sel_e               sel;
        logic [7:0]             data;
    } cpu_wr_t;

    // Tile ROM address
    // Tile row and column, then the line and pixel inside the 8x8 tile
    typedef struct packed {
        logic [4:0] row;
        logic [5:0] col;
        logic [2:0] line;
        logic [2:0] px;
    } tile_addr_t;

    // Pixel of one layer
    // opaque is clear when the color index is zero
    typedef struct packed {
        logic [3:0] color;
        logic       opaque;
    } layer_pxl_t;

    // Mixed output pixel, tagged with the layer that won
    typedef struct packed {
        logic [`LAYER_BITS-1:0] layer;
        logic [3:0]             color;
    } pxl_t;

endpackage

//--- video_cen.sv
`timescale 1ns/100ps

module video_cen (
    input  logic clk,
    input  logic arst_n,
    output logic pxl2_cen,
    output logic pxl_cen
);

    // Free-running divide-by-8 counter on the 48 MHz clock
    logic [2:0] cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= 3'd0;
        end else begin
            cnt <= cnt + 3'd1;
        end
    end

    // Enables are registered from the count before it wraps
    // pxl2_cen fires on counts 2 and 6, so once every 4 clk
    // pxl_cen fires on count 6 only, so it lands on every second pxl2_cen
    // First pxl_cen is the 8th clk after reset goes away
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            // 12 MHz
            pxl2_cen <= (cnt[1:0] == 2'd2);
            // 6 MHz
            pxl_cen  <= (cnt == 3'd6);
        end
    end

endmodule

//--- video_timer.sv
`timescale 1ns/100ps
`include "video_macros.svh"

module video_timer (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               pxl_cen,
    output video_pkg::timing_t timing
);

    // Next raster position
    logic [8:0] h_nxt;
    logic [8:0] v_nxt;
    // Flags derived from the next position
    logic       lhbl_nxt;
    logic       lvbl_nxt;
    logic       hs_nxt;
    logic       vs_nxt;

    // Counter advance
    // v moves only when h wraps to the start of a line
    always_comb begin
        h_nxt = timing.h + 9'd1;
        v_nxt = timing.v;
        if (timing.h == 9'(`H_TOTAL - 1)) begin
            h_nxt = 9'd0;
            if (timing.v == 9'(`V_TOTAL - 1)) begin
                v_nxt = 9'd0;
            end else begin
                v_nxt = timing.v + 9'd1;
            end
        end
    end

    // Blanking is active low, the flags are high inside the visible area
    always_comb begin
        lhbl_nxt = (h_nxt < 9'(`H_ACTIVE));
        lvbl_nxt = (v_nxt < 9'(`V_ACTIVE));
        // Sync windows include the start and exclude the end
        hs_nxt   = (h_nxt >= 9'(`HS_START)) && (h_nxt < 9'(`HS_END));
        vs_nxt   = (v_nxt >= 9'(`VS_START)) && (v_nxt < 9'(`VS_END));
    end

    // Counters and flags move together so they always describe one pixel
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            timing.h    <= 9'd0;
            timing.v    <= 9'd0;
            // Position 0,0 is visible
            timing.lhbl <= 1'b1;
            timing.lvbl <= 1'b1;
            timing.hs   <= 1'b0;
            timing.vs   <= 1'b0;
        end else if (pxl_cen) begin
            timing.h    <= h_nxt;
            timing.v    <= v_nxt;
            timing.lhbl <= lhbl_nxt;
            timing.lvbl <= lvbl_nxt;
            timing.hs   <= hs_nxt;
            timing.vs   <= vs_nxt;
        end
    end

endmodule

//--- scroll_regs.sv
`timescale 1ns/100ps
`include "video_macros.svh"

module scroll_regs (
    input  logic                clk,
    input  logic                arst_n,
    input  video_pkg::cpu_wr_t  cpu,
    output video_pkg::scroll_t  scroll [`NUM_LAYERS]
);

    localparam int LW = `LAYER_BITS;

    // One register set per layer
    // A layer index with no matching set is simply not decoded
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < `NUM_LAYERS; k++) begin
                scroll[k] <= '0;
            end
        end else begin
            for (int k = 0; k < `NUM_LAYERS; k++) begin
                if (cpu.wr && (cpu.layer == LW'(k))) begin
                    // Byte lane picked by the register select
                    case (cpu.sel)
                        video_pkg::REG_HSCROLL_LO: begin
                            scroll[k].hscroll[7:0] <= cpu.data;
                        end
                        video_pkg::REG_HSCROLL_HI: begin
                            // Only bit 8 exists above the low byte
                            scroll[k].hscroll[8] <= cpu.data[0];
                        end
                        video_pkg::REG_VSCROLL: begin
                            scroll[k].vscroll <= cpu.data;
                        end
                        default: begin
                            // Unused select code, nothing changes
                            scroll[k] <= scroll[k];
                        end
                    endcase
                end
            end
        end
    end

endmodule

//--- tile_layer.sv
`timescale 1ns/100ps

module tile_layer (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   pxl_cen,
    input  video_pkg::timing_t     timing,
    input  video_pkg::scroll_t     scroll,
    output video_pkg::tile_addr_t  rom_addr,
    input  logic [3:0]             rom_data,
    output video_pkg::layer_pxl_t  lpxl
);

    // Scrolled position in the tile map
    logic [8:0] x;
    logic [7:0] y;

    // Horizontal map is 512 pixels wide, so the 9-bit sum wraps for free
    assign x = timing.h + scroll.hscroll;
    // Vertical map is 256 lines tall
    // Dropping bit 8 of v keeps the sum modulo 256
    assign y = timing.v[7:0] + scroll.vscroll;

    // Stage 1
    // Address goes out on a pxl_cen, the ROM has one pixel period to answer
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rom_addr <= '0;
        end else if (pxl_cen) begin
            // 8x8 tiles, upper bits select the tile and lower bits the texel
            rom_addr.row  <= y[7:3];
            rom_addr.line <= y[2:0];
            rom_addr.col  <= x[8:3];
            rom_addr.px   <= x[2:0];
        end
    end

    // Stage 2
    // ROM data is taken on the following pxl_cen
    // Color 0 is the transparent pen
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lpxl <= '0;
        end else if (pxl_cen) begin
            lpxl.color  <= rom_data;
            lpxl.opaque <= |rom_data;
        end
    end

endmodule

//--- layer_mixer.sv
`timescale 1ns/100ps
`include "video_macros.svh"

module layer_mixer (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   pxl_cen,
    input  video_pkg::timing_t     timing,
    input  video_pkg::layer_pxl_t  lpxl [`NUM_LAYERS],
    output video_pkg::pxl_t        pxl,
    output logic                   LHBL_dly,
    output logic                   LVBL_dly
);

    localparam int LW = `LAYER_BITS;

    // Blanking pipeline, one stage per pxl_cen
    // Stage 2 holds the flags of the pixel now at the layer outputs
    logic [2:0]     lhbl_pipe;
    logic [2:0]     lvbl_pipe;
    // Priority result
    video_pkg::pxl_t win;
    logic            found;

    // Lowest index wins, so walk from the back layer to the front one
    always_comb begin
        win   = '0;
        found = 1'b0;
        for (int k = `NUM_LAYERS - 1; k >= 0; k--) begin
            if (lpxl[k].opaque) begin
                win.layer = LW'(k);
                win.color = lpxl[k].color;
                found     = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // Matches the timer, which starts inside the visible area
            lhbl_pipe <= 3'b111;
            lvbl_pipe <= 3'b111;
            pxl       <= '0;
        end else if (pxl_cen) begin
            lhbl_pipe <= {lhbl_pipe[1:0], timing.lhbl};
            lvbl_pipe <= {lvbl_pipe[1:0], timing.lvbl};
            // Gated with the flags that move into stage 3 on this same edge
            if (found && lhbl_pipe[1] && lvbl_pipe[1]) begin
                pxl <= win;
            end else begin
                pxl <= '0;
            end
        end
    end

    // Third stage lines up with pxl
    assign LHBL_dly = lhbl_pipe[2];
    assign LVBL_dly = lvbl_pipe[2];

endmodule

//--- contra_video.sv
`timescale 1ns/100ps
`include "video_macros.svh"

module contra_video (
    input  logic                   clk,
    input  logic                   arst_n,
    input  video_pkg::cpu_wr_t     cpu,
    output video_pkg::tile_addr_t  rom_addr [`NUM_LAYERS],
    input  logic [3:0]             rom_data [`NUM_LAYERS],
    output logic                   pxl2_cen,
    output logic                   pxl_cen,
    output logic                   LHBL,
    output logic                   LVBL,
    output logic                   LHBL_dly,
    output logic                   LVBL_dly,
    output logic                   HS,
    output logic                   VS,
    output video_pkg::pxl_t        pxl
);

    video_pkg::timing_t    timing;
    video_pkg::scroll_t    scroll [`NUM_LAYERS];
    video_pkg::layer_pxl_t lpxl   [`NUM_LAYERS];

    // 48 MHz down to 12 and 6 MHz enables
    video_cen u_cen (
        .clk      (clk),
        .arst_n   (arst_n),
        .pxl2_cen (pxl2_cen),
        .pxl_cen  (pxl_cen)
    );

    video_timer u_timer (
        .clk     (clk),
        .arst_n  (arst_n),
        .pxl_cen (pxl_cen),
        .timing  (timing)
    );

    // Undelayed raster flags, straight from the timer
    assign LHBL = timing.lhbl;
    assign LVBL = timing.lvbl;
    assign HS   = timing.hs;
    assign VS   = timing.vs;

    scroll_regs u_scroll (
        .clk    (clk),
        .arst_n (arst_n),
        .cpu    (cpu),
        .scroll (scroll)
    );

    // One tile layer per ROM port
    for (genvar i = 0; i < `NUM_LAYERS; i++) begin : g_layer
        tile_layer u_layer (
            .clk      (clk),
            .arst_n   (arst_n),
            .pxl_cen  (pxl_cen),
            .timing   (timing),
            .scroll   (scroll[i]),
            .rom_addr (rom_addr[i]),
            .rom_data (rom_data[i]),
            .lpxl     (lpxl[i])
        );
    end

    layer_mixer u_mixer (
        .clk      (clk),
        .arst_n   (arst_n),
        .pxl_cen  (pxl_cen),
        .timing   (timing),
        .lpxl     (lpxl),
        .pxl      (pxl),
        .LHBL_dly (LHBL_dly),
        .LVBL_dly (LVBL_dly)
    );

endmodule

//--- tb_contra_video.sv
`timescale 1ns/100ps
`include "video_macros.svh"

module tb_contra_video;

    localparam int LB = `LAYER_BITS;
    localparam int NL = `NUM_LAYERS;

    logic                   clk;
    logic                   arst_n;
    video_pkg::cpu_wr_t     cpu;
    video_pkg::tile_addr_t  rom_addr [NL];
    logic [3:0]             rom_data [NL];
    logic                   pxl2_cen;
    logic                   pxl_cen;
    logic                   LHBL;
    logic                   LVBL;
    logic                   LHBL_dly;
    logic                   LVBL_dly;
    logic                   HS;
    logic                   VS;
    video_pkg::pxl_t        pxl;

    int          errors;
    int          checks;
    logic [31:0] lfsr;
    // Layer 0 turns transparent on odd tile columns while set
    logic        hole_en;
    // Scroll values as the CPU wrote them
    logic [8:0]  sc_h [NL];
    logic [7:0]  sc_v [NL];
    // Raster position rebuilt from the sync edges
    int          th;
    int          tv;
    logic        hs_q;
    logic        vs_q;
    // Position history per pixel slot, index 0 is the current one
    int          hist_h [4];
    int          hist_v [4];

    contra_video uut (
        .clk      (clk),
        .arst_n   (arst_n),
        .cpu      (cpu),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .pxl2_cen (pxl2_cen),
        .pxl_cen  (pxl_cen),
        .LHBL     (LHBL),
        .LVBL     (LVBL),
        .LHBL_dly (LHBL_dly),
        .LVBL_dly (LVBL_dly),
        .HS       (HS),
        .VS       (VS),
        .pxl      (pxl)
    );

    // 50 MHz stand-in for the 48 MHz board clock
    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    task automatic rand_bits(input int n, output logic [31:0] r);
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
    endtask

    // Tile ROM contents
    // Address layout is row, col, line, px from the top bit down
    function automatic logic [3:0] rom_value(input int layer, input logic [16:0] a);
        logic [3:0] d;
        d = a[15:12] ^ a[9:6] ^ {1'b0, a[5:3]} ^ {1'b0, a[2:0]} ^ layer[3:0];
        if (hole_en && layer == 0 && a[6]) begin
            d = 4'd0;
        end
        return d;
    endfunction

    // Expected tile address of a raster position under one scroll setting
    function automatic logic [16:0] exp_addr(input int h, input int v, input int hs, input int vs);
        int x;
        int y;
        x = (h + hs) % 512;
        y = (v + vs) % 256;
        return {y[7:3], x[8:3], y[2:0], x[2:0]};
    endfunction

    // Expected mixed pixel, front layer first, zero outside the visible area
    function automatic logic [LB+3:0] exp_pixel(input int h, input int v);
        logic [3:0] d;
        if (h >= `H_ACTIVE || v >= `V_ACTIVE) begin
            return '0;
        end
        for (int k = 0; k < NL; k++) begin
            d = rom_value(k, exp_addr(h, v, sc_h[k], sc_v[k]));
            if (d != 4'd0) begin
                return {LB'(k), d};
            end
        end
        return '0;
    endfunction

    // ROM answers one ns after each edge, well inside the pixel period
    always @(posedge clk) begin
        #1;
        for (int i = 0; i < NL; i++) begin
            rom_data[i] = rom_value(i, rom_addr[i]);
        end
    end

    // Raster tracker, one step per pixel slot
    // VS rises at h 0 of line VS_START, HS rises at h HS_START
    always @(negedge clk) begin
        if (pxl_cen) begin
            for (int k = 3; k > 0; k--) begin
                hist_h[k] = hist_h[k-1];
                hist_v[k] = hist_v[k-1];
            end
            if (VS && !vs_q) begin
                th = 0;
                tv = `VS_START;
            end else if (HS && !hs_q) begin
                th = `HS_START;
            end else begin
                th = th + 1;
                if (th == `H_TOTAL) begin
                    th = 0;
                    tv = (tv + 1) % `V_TOTAL;
                end
            end
            hs_q = HS;
            vs_q = VS;
            hist_h[0] = th;
            hist_v[0] = tv;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic abort_run(input string why);
        $display("Run stopped: %s", why);
        $display("Checks %0d, errors %0d", checks, errors);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic report_test(input string name, input int err0);
        if (errors == err0) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: %0d errors", name, errors - err0);
        end
    endtask

    // Steps to the next pixel slot, sampled just after the falling edge
    task automatic next_pixel;
        int n;
        n = 0;
        do begin
            @(negedge clk);
            #1;
            n++;
            if (n > 16) begin
                abort_run("no pxl_cen within 16 clock cycles");
            end
        end while (!pxl_cen);
    endtask

    task automatic wait_sync_rise(input logic vert, input int limit);
        int   n;
        logic prev;
        logic rose;
        n = 0;
        rose = 1'b0;
        while (!rose) begin
            prev = vert ? VS : HS;
            next_pixel();
            rose = (vert ? VS : HS) && !prev;
            n++;
            if (!rose && n > limit) begin
                abort_run(vert ? "VS never rose" : "HS never rose");
            end
        end
    endtask

    task automatic wait_position(input int h, input int v);
        int n;
        n = 0;
        do begin
            next_pixel();
            n++;
            if (n > 2 * `H_TOTAL * `V_TOTAL) begin
                abort_run("raster position never reached");
            end
        end while (hist_h[0] != h || hist_v[0] != v);
    endtask

    task automatic cpu_write(input logic [LB-1:0] layer, input video_pkg::reg_sel_e sel,
                             input logic [7:0] data);
        @(posedge clk);
        #1;
        cpu.wr    = 1'b1;
        cpu.layer = layer;
        cpu.sel   = sel;
        cpu.data  = data;
        @(posedge clk);
        #1;
        cpu.wr    = 1'b0;
    endtask

    // Address lags the raster by one slot
    task automatic check_addr_line;
        for (int n = 0; n < `H_TOTAL; n++) begin
            next_pixel();
            for (int i = 0; i < NL; i++) begin
                check($sformatf("rom_addr[%0d]", i), rom_addr[i],
                      exp_addr(hist_h[1], hist_v[1], sc_h[i], sc_v[i]));
            end
        end
    endtask

    task automatic enables_test;
        int err0;
        int n1;
        int n2;
        int last;
        err0 = errors;
        n1 = 0;
        n2 = 0;
        last = -1;
        for (int i = 0; i < 64; i++) begin
            @(negedge clk);
            #1;
            if (pxl2_cen) begin
                n2++;
            end
            if (pxl_cen) begin
                n1++;
                check("pxl2_cen", pxl2_cen, 1);
                if (last >= 0) begin
                    check("pxl_cen spacing", i - last, 8);
                end else begin
                    // First enable falls in the 8th clk after reset release
                    check("first pxl_cen", i, 7);
                end
                last = i;
            end
        end
        check("pxl_cen count", n1, 8);
        check("pxl2_cen count", n2, 16);
        report_test("clock enables", err0);
    endtask

    task automatic geometry_test;
        int   err0;
        int   pix;
        int   act;
        int   hsw;
        int   lines;
        int   vis;
        int   vsl;
        logic prev_h;
        logic prev_v;
        logic rose;
        err0 = errors;
        wait_sync_rise(1'b0, 2 * `H_TOTAL);
        pix = 0;
        act = 0;
        hsw = 0;
        rose = 1'b0;
        // One full line, every h value exactly once
        while (!rose) begin
            prev_h = HS;
            next_pixel();
            pix++;
            if (LHBL) begin
                act++;
            end
            if (HS) begin
                hsw++;
            end
            rose = HS && !prev_h;
            if (!rose && pix > 2 * `H_TOTAL) begin
                abort_run("HS stopped toggling");
            end
        end
        check("pixels per line", pix, `H_TOTAL);
        check("visible pixels", act, `H_ACTIVE);
        check("HS width", hsw, `HS_END - `HS_START);
        wait_sync_rise(1'b1, 2 * `H_TOTAL * `V_TOTAL);
        lines = 0;
        vis = 0;
        vsl = 0;
        pix = 0;
        rose = 1'b0;
        // LVBL only moves at h 0, so the HS edge is a safe point to read it
        while (!rose) begin
            prev_h = HS;
            prev_v = VS;
            next_pixel();
            pix++;
            if (HS && !prev_h) begin
                lines++;
                if (LVBL) begin
                    vis++;
                end
                if (VS) begin
                    vsl++;
                end
            end
            rose = VS && !prev_v;
            if (!rose && pix > 2 * `H_TOTAL * `V_TOTAL) begin
                abort_run("VS stopped toggling");
            end
        end
        check("lines per frame", lines, `V_TOTAL);
        check("visible lines", vis, `V_ACTIVE);
        check("VS width", vsl, `VS_END - `VS_START);
        report_test("raster geometry", err0);
    endtask

    task automatic unscrolled_test;
        int err0;
        err0 = errors;
        repeat (4) next_pixel();
        check_addr_line();
        report_test("unscrolled address", err0);
    endtask

    task automatic scroll_test;
        int          err0;
        logic [31:0] r;
        err0 = errors;
        for (int i = 0; i < NL; i++) begin
            rand_bits(16, r);
            // Only bit 0 of the high byte lands in hscroll
            sc_h[i] = {r[8], r[7:0]};
            cpu_write(LB'(i), video_pkg::REG_HSCROLL_LO, r[7:0]);
            cpu_write(LB'(i), video_pkg::REG_HSCROLL_HI, r[15:8]);
            rand_bits(8, r);
            sc_v[i] = r[7:0];
            cpu_write(LB'(i), video_pkg::REG_VSCROLL, r[7:0]);
        end
        // Write to a layer that does not exist
        if (NL < 4) begin
            cpu_write(LB'(NL), video_pkg::REG_VSCROLL, 8'hff);
        end
        repeat (4) next_pixel();
        check_addr_line();
        report_test("random scroll", err0);
    endtask

    task automatic priority_test;
        int            err0;
        int            n0;
        int            n1;
        logic [LB+3:0] e;
        err0 = errors;
        n0 = 0;
        n1 = 0;
        hole_en = 1'b1;
        repeat (4) next_pixel();
        wait_position(0, 16);
        for (int n = 0; n < `H_TOTAL; n++) begin
            next_pixel();
            // Mixed pixel lags the raster by three slots
            e = exp_pixel(hist_h[3], hist_v[3]);
            check("pxl", pxl, e);
            if (pxl.layer == LB'(1)) begin
                n1++;
            end else if (pxl.color != 4'd0) begin
                n0++;
            end
        end
        check("layer 1 pixels seen", n1 != 0, 1);
        check("layer 0 pixels seen", n0 != 0, 1);
        hole_en = 1'b0;
        repeat (4) next_pixel();
        report_test("priority and transparency", err0);
    endtask

    task automatic blanking_test;
        int err0;
        err0 = errors;
        // Three lines across the start of vertical blanking
        wait_position(0, `V_ACTIVE - 2);
        for (int n = 0; n < 3 * `H_TOTAL; n++) begin
            next_pixel();
            check("LHBL", LHBL, hist_h[0] < `H_ACTIVE);
            check("LVBL", LVBL, hist_v[0] < `V_ACTIVE);
            check("LHBL_dly", LHBL_dly, hist_h[3] < `H_ACTIVE);
            check("LVBL_dly", LVBL_dly, hist_v[3] < `V_ACTIVE);
            if (!LHBL_dly || !LVBL_dly) begin
                check("pxl in blanking", pxl, 0);
            end else begin
                check("pxl", pxl, exp_pixel(hist_h[3], hist_v[3]));
            end
        end
        report_test("blanking alignment", err0);
    endtask

    initial begin
        errors  = 0;
        checks  = 0;
        lfsr    = 32'h8f09_4023;
        hole_en = 1'b0;
        cpu     = '0;
        arst_n  = 1'b0;
        th      = 0;
        tv      = 0;
        hs_q    = 1'b0;
        vs_q    = 1'b0;
        for (int i = 0; i < NL; i++) begin
            rom_data[i] = 4'd0;
            sc_h[i]     = 9'd0;
            sc_v[i]     = 8'd0;
        end
        for (int k = 0; k < 4; k++) begin
            hist_h[k] = 0;
            hist_v[k] = 0;
        end
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;
        enables_test();
        geometry_test();
        unscrolled_test();
        scroll_test();
        priority_test();
        blanking_test();
        $display("Tests done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+.
video_pkg.sv
video_cen.sv
video_timer.sv
scroll_regs.sv
tile_layer.sv
layer_mixer.sv
contra_video.sv
tb_contra_video.sv
